// File: tinker_pkg.sv
/* Tinker core definitions
   Widths, opcodes, reset PC and the two views of the instruction word */
`default_nettype none

package tinker_pkg;

    localparam int XLEN    = 64;
    localparam int INSN_W  = 32;
    localparam int REG_AW  = 5;
    localparam int OP_W    = 5;
    localparam int LIT_W   = 12;
    localparam int IMEM_AW = 8;   // 256 instruction words

    localparam logic [XLEN-1:0] RESET_PC = 64'h2000;
    localparam logic [XLEN-1:0] PC_STEP  = 64'd4;

    // ####################
    // Opcodes
    localparam logic [OP_W-1:0] OP_AND     = 5'h00;
    localparam logic [OP_W-1:0] OP_OR      = 5'h01;
    localparam logic [OP_W-1:0] OP_XOR     = 5'h02;
    localparam logic [OP_W-1:0] OP_NOT     = 5'h03;
    localparam logic [OP_W-1:0] OP_SHFTR   = 5'h04;
    localparam logic [OP_W-1:0] OP_SHFTRI  = 5'h05;
    localparam logic [OP_W-1:0] OP_SHFTL   = 5'h06;
    localparam logic [OP_W-1:0] OP_SHFTLI  = 5'h07;
    localparam logic [OP_W-1:0] OP_BR      = 5'h08;
    localparam logic [OP_W-1:0] OP_BRRI    = 5'h0A;
    localparam logic [OP_W-1:0] OP_BRNZ    = 5'h0B;
    localparam logic [OP_W-1:0] OP_BRGT    = 5'h0E;
    localparam logic [OP_W-1:0] OP_PRIV    = 5'h0F;
    localparam logic [OP_W-1:0] OP_MOV_MEM = 5'h10;
    localparam logic [OP_W-1:0] OP_MOV_REG = 5'h11;
    localparam logic [OP_W-1:0] OP_MOV_LIT = 5'h12;
    localparam logic [OP_W-1:0] OP_MOV_STR = 5'h13;
    localparam logic [OP_W-1:0] OP_ADD     = 5'h18;
    localparam logic [OP_W-1:0] OP_ADDI    = 5'h19;
    localparam logic [OP_W-1:0] OP_SUB     = 5'h1A;
    localparam logic [OP_W-1:0] OP_SUBI    = 5'h1B;
    localparam logic [OP_W-1:0] OP_NOP     = 5'h1F;   // Unassigned code, used for bubbles

    // ####################
    // Instruction word
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]   opcode;
            logic [REG_AW-1:0] rd;
            logic [REG_AW-1:0] rs;
            logic [REG_AW-1:0] rt;
            logic [LIT_W-1:0]  unused;
        } r;
        struct packed {
            logic [OP_W-1:0]   opcode;
            logic [REG_AW-1:0] rd;
            logic [9:0]        unused;
            logic [LIT_W-1:0]  lit;
        } i;
    } insn_t;

    localparam logic [INSN_W-1:0] NOP_INSN = {OP_NOP, 27'd0};

endpackage

`default_nettype wire

// File: pipe_control.sv
/* Pipeline control
   Forwarding select, load-use stall, branch flush and the halt latch */
`default_nettype none

module pipe_control (
    input  wire                           clk,
    input  wire                           reset,
    input  wire [tinker_pkg::REG_AW-1:0]  rs_addr,
    input  wire [tinker_pkg::REG_AW-1:0]  rt_addr,
    input  wire                           rs_used,
    input  wire                           rt_used,
    input  wire [tinker_pkg::REG_AW-1:0]  ex_rd,
    input  wire                           ex_wr,
    input  wire                           ex_load,
    input  wire [tinker_pkg::REG_AW-1:0]  mem_rd,
    input  wire                           mem_wr,
    input  wire                           branch_taken,
    input  wire                           halt_mem,
    output logic [1:0]                    fwd_rs_sel,
    output logic [1:0]                    fwd_rt_sel,
    output logic                          stall,
    output logic                          flush,
    output logic                          halted
);

    // 0 register file, 1 execute result, 2 write-back value
    function automatic logic [1:0] fwd_sel(input logic [tinker_pkg::REG_AW-1:0] src);
        if (ex_wr && ex_rd == src)
            return 2'd1;   // Youngest producer wins
        if (mem_wr && mem_rd == src)
            return 2'd2;
        return 2'd0;
    endfunction

    always_comb begin
        fwd_rs_sel = fwd_sel(rs_addr);
        fwd_rt_sel = fwd_sel(rt_addr);
    end

    // Load result only exists one stage later
    assign stall = ex_load && ((rs_used && ex_rd == rs_addr) || (rt_used && ex_rd == rt_addr));
    assign flush = branch_taken;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt_mem) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: fetch_stage.sv
/* Fetch stage
   PC, instruction memory with its load port, fetch/decode register */
`default_nettype none

module fetch_stage (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            load_en,
    input  wire [tinker_pkg::IMEM_AW-1:0]  load_addr,
    input  wire [tinker_pkg::INSN_W-1:0]   load_data,
    input  wire                            stall,
    input  wire                            flush,
    input  wire                            halted,
    input  wire [tinker_pkg::XLEN-1:0]     branch_pc,
    output logic [tinker_pkg::XLEN-1:0]    de_pc,
    output logic [tinker_pkg::INSN_W-1:0]  de_insn
);

    logic [tinker_pkg::XLEN-1:0]   pc;
    logic [tinker_pkg::INSN_W-1:0] imem [2**tinker_pkg::IMEM_AW];
    logic [tinker_pkg::INSN_W-1:0] fetch_insn;

    // Word index, byte offset dropped
    assign fetch_insn = imem[pc[tinker_pkg::IMEM_AW+1:2]];

    // Program is written only while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= tinker_pkg::RESET_PC;
        end else if (flush) begin
            pc <= branch_pc;
        end else if (!stall && !halted) begin
            pc <= pc + tinker_pkg::PC_STEP;
        end
    end

    // ####################
    // Fetch/decode register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            de_insn <= tinker_pkg::NOP_INSN;
        end else if (flush) begin
            de_insn <= tinker_pkg::NOP_INSN;   // Kill wrong-path fetch
        end else if (!stall) begin
            de_insn <= fetch_insn;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            de_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
/* Decode stage
   Instruction decode, register file, operand bypass, decode/execute register */
`default_nettype none

module decode_stage (
    input  wire                            clk,
    input  wire                            reset,
    input  wire [tinker_pkg::XLEN-1:0]     de_pc,
    input  wire [tinker_pkg::INSN_W-1:0]   de_insn,
    input  wire [1:0]                      fwd_rs_sel,
    input  wire [1:0]                      fwd_rt_sel,
    input  wire [tinker_pkg::XLEN-1:0]     ex_result,
    input  wire [tinker_pkg::XLEN-1:0]     wb_data,
    input  wire [tinker_pkg::REG_AW-1:0]   wb_rd,
    input  wire                            wb_en,
    input  wire                            stall,
    input  wire                            flush,
    output logic [tinker_pkg::REG_AW-1:0]  rs_addr,
    output logic [tinker_pkg::REG_AW-1:0]  rt_addr,
    output logic                           rs_used,
    output logic                           rt_used,
    output logic [tinker_pkg::XLEN-1:0]    ex_pc,
    output logic [tinker_pkg::OP_W-1:0]    ex_op,
    output logic [tinker_pkg::XLEN-1:0]    ex_a,
    output logic [tinker_pkg::XLEN-1:0]    ex_b,
    output logic [tinker_pkg::XLEN-1:0]    ex_c,
    output logic [tinker_pkg::LIT_W-1:0]   ex_lit,
    output logic [tinker_pkg::REG_AW-1:0]  ex_rd,
    output logic                           ex_wr,
    output logic                           ex_load,
    output logic                           ex_store
);

    tinker_pkg::insn_t               insn;
    logic [tinker_pkg::XLEN-1:0]     regs [2**tinker_pkg::REG_AW];
    logic [tinker_pkg::OP_W-1:0]     op;
    logic [tinker_pkg::REG_AW-1:0]   rd;
    logic [tinker_pkg::XLEN-1:0]     lit_ext;
    logic [tinker_pkg::XLEN-1:0]     rs_val;
    logic [tinker_pkg::XLEN-1:0]     rt_val;
    logic [tinker_pkg::XLEN-1:0]     rd_val;
    logic                            imm_form;
    logic                            rd_on_rt;
    logic                            lit_sel;
    logic                            wr;
    logic                            load;
    logic                            store;
    logic                            bubble;

    assign insn    = de_insn;
    assign op      = insn.r.opcode;
    assign rd      = insn.r.rd;
    assign lit_ext = {{(tinker_pkg::XLEN-tinker_pkg::LIT_W){insn.i.lit[tinker_pkg::LIT_W-1]}},
                      insn.i.lit};

    // ####################
    // Decode
    assign imm_form = op inside {tinker_pkg::OP_ADDI, tinker_pkg::OP_SUBI, tinker_pkg::OP_SHFTRI,
                                 tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOV_LIT};
    assign load     = op == tinker_pkg::OP_MOV_MEM;
    assign store    = op == tinker_pkg::OP_MOV_STR;
    assign lit_sel  = imm_form || load || store;
    // Store base and branch targets come in on the rt port
    assign rd_on_rt = op inside {tinker_pkg::OP_MOV_STR, tinker_pkg::OP_BR, tinker_pkg::OP_BRNZ};
    assign wr       = imm_form || load || (op inside {
        tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR, tinker_pkg::OP_NOT,
        tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTL, tinker_pkg::OP_ADD, tinker_pkg::OP_SUB,
        tinker_pkg::OP_MOV_REG});
    assign rs_used  = wr || store || op == tinker_pkg::OP_BRNZ || op == tinker_pkg::OP_BRGT;
    assign rt_used  = rd_on_rt || (op inside {
        tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR, tinker_pkg::OP_SHFTR,
        tinker_pkg::OP_SHFTL, tinker_pkg::OP_ADD, tinker_pkg::OP_SUB, tinker_pkg::OP_BRGT});

    assign rs_addr = imm_form ? insn.i.rd : insn.r.rs;   // Immediate forms read rd
    assign rt_addr = rd_on_rt ? rd : insn.r.rt;

    // ####################
    // Operand read and bypass
    assign rs_val = (fwd_rs_sel == 2'd1) ? ex_result :
                    (fwd_rs_sel == 2'd2) ? wb_data : regs[rs_addr];
    assign rt_val = (fwd_rt_sel == 2'd1) ? ex_result :
                    (fwd_rt_sel == 2'd2) ? wb_data : regs[rt_addr];

    // Third port, only the BRGT target
    assign rd_val = (ex_wr && ex_rd == rd) ? ex_result :
                    (wb_en && wb_rd == rd) ? wb_data : regs[rd];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**tinker_pkg::REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // ####################
    // Decode/execute register
    assign bubble = flush || stall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_op    <= tinker_pkg::OP_NOP;
            ex_wr    <= 1'b0;
            ex_load  <= 1'b0;
            ex_store <= 1'b0;
        end else begin
            ex_op    <= bubble ? tinker_pkg::OP_NOP : op;
            ex_wr    <= wr && !bubble;
            ex_load  <= load && !bubble;
            ex_store <= store && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc  <= de_pc;
        ex_a   <= rs_val;
        ex_b   <= lit_sel ? lit_ext : rt_val;
        ex_c   <= (op == tinker_pkg::OP_BRGT) ? rd_val : rt_val;
        ex_lit <= insn.i.lit;
        ex_rd  <= rd;
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
/* Execute and memory stages
   ALU, address adder, branch resolve, execute/memory register, write-back select */
`default_nettype none

module execute_stage (
    input  wire                            clk,
    input  wire                            reset,
    input  wire [tinker_pkg::XLEN-1:0]     ex_pc,
    input  wire [tinker_pkg::OP_W-1:0]     ex_op,
    input  wire [tinker_pkg::XLEN-1:0]     ex_a,
    input  wire [tinker_pkg::XLEN-1:0]     ex_b,
    input  wire [tinker_pkg::XLEN-1:0]     ex_c,
    input  wire [tinker_pkg::LIT_W-1:0]    ex_lit,
    input  wire [tinker_pkg::REG_AW-1:0]   ex_rd,
    input  wire                            ex_wr,
    input  wire                            ex_load,
    input  wire                            ex_store,
    input  wire [tinker_pkg::XLEN-1:0]     dmem_rdata,
    output logic [tinker_pkg::XLEN-1:0]    ex_result,
    output logic                           branch_taken,
    output logic [tinker_pkg::XLEN-1:0]    branch_pc,
    output logic [tinker_pkg::REG_AW-1:0]  mem_rd,
    output logic                           mem_wr,
    output logic [tinker_pkg::XLEN-1:0]    wb_data,
    output logic                           halt_mem,
    output logic                           dmem_read,
    output logic                           dmem_write,
    output logic [tinker_pkg::XLEN-1:0]    dmem_addr,
    output logic [tinker_pkg::XLEN-1:0]    dmem_wdata
);

    logic [tinker_pkg::XLEN-1:0] lit_ext;
    logic [tinker_pkg::XLEN-1:0] addr;
    logic [tinker_pkg::XLEN-1:0] mem_result;
    logic                        taken;
    logic                        is_halt;

    assign lit_ext = {{(tinker_pkg::XLEN-tinker_pkg::LIT_W){ex_lit[tinker_pkg::LIT_W-1]}}, ex_lit};

    // ####################
    // ALU
    always_comb begin
        case (ex_op)
            tinker_pkg::OP_AND:     ex_result = ex_a & ex_b;
            tinker_pkg::OP_OR:      ex_result = ex_a | ex_b;
            tinker_pkg::OP_XOR:     ex_result = ex_a ^ ex_b;
            tinker_pkg::OP_NOT:     ex_result = ~ex_a;
            tinker_pkg::OP_SHFTR,
            tinker_pkg::OP_SHFTRI:  ex_result = ex_a >> ex_b[5:0];
            tinker_pkg::OP_SHFTL,
            tinker_pkg::OP_SHFTLI:  ex_result = ex_a << ex_b[5:0];
            tinker_pkg::OP_ADD,
            tinker_pkg::OP_ADDI:    ex_result = ex_a + ex_b;
            tinker_pkg::OP_SUB,
            tinker_pkg::OP_SUBI:    ex_result = ex_a - ex_b;
            tinker_pkg::OP_MOV_REG: ex_result = ex_a;
            tinker_pkg::OP_MOV_LIT: ex_result = {ex_a[tinker_pkg::XLEN-1:tinker_pkg::LIT_W],
                                                 ex_b[tinker_pkg::LIT_W-1:0]};
            default:                ex_result = '0;
        endcase
    end

    assign addr = (ex_store ? ex_c : ex_a) + ex_b;   // Store base is rd

    // ####################
    // Branch resolve
    assign taken = ex_op == tinker_pkg::OP_BR || ex_op == tinker_pkg::OP_BRRI
                || (ex_op == tinker_pkg::OP_BRNZ && ex_a != '0)
                || (ex_op == tinker_pkg::OP_BRGT && $signed(ex_a) > $signed(ex_b));
    assign branch_taken = taken && !halt_mem;
    assign branch_pc    = (ex_op == tinker_pkg::OP_BRRI) ? ex_pc + lit_ext : ex_c;
    assign is_halt      = ex_op == tinker_pkg::OP_PRIV && ex_lit == '0;

    // Execute/memory register, nothing behind a halt commits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_wr     <= 1'b0;
            dmem_read  <= 1'b0;
            dmem_write <= 1'b0;
            halt_mem   <= 1'b0;
        end else begin
            mem_wr     <= ex_wr && !halt_mem;
            dmem_read  <= ex_load && !halt_mem;
            dmem_write <= ex_store && !halt_mem;
            halt_mem   <= halt_mem || is_halt;   // Sticky
        end
    end

    always_ff @(posedge clk) begin
        mem_rd     <= ex_rd;
        mem_result <= ex_result;
        dmem_addr  <= addr;
        dmem_wdata <= ex_a;
    end

    assign wb_data = dmem_read ? dmem_rdata : mem_result;

endmodule

`default_nettype wire

// File: tinker_core.sv
/* Tinker core
   Four-stage in-order pipeline, data memory on an external bus */
`default_nettype none

module tinker_core (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            load_en,
    input  wire [tinker_pkg::IMEM_AW-1:0]  load_addr,
    input  wire [tinker_pkg::INSN_W-1:0]   load_data,
    output logic                           dmem_read,
    output logic                           dmem_write,
    output logic [tinker_pkg::XLEN-1:0]    dmem_addr,
    output logic [tinker_pkg::XLEN-1:0]    dmem_wdata,
    input  wire [tinker_pkg::XLEN-1:0]     dmem_rdata,
    output logic                           hlt
);

    // Control
    logic [1:0]                    fwd_rs_sel;
    logic [1:0]                    fwd_rt_sel;
    logic                          stall;
    logic                          flush;
    logic                          branch_taken;
    logic                          halt_mem;
    logic [tinker_pkg::XLEN-1:0]   branch_pc;

    // Fetch to decode
    logic [tinker_pkg::XLEN-1:0]   de_pc;
    logic [tinker_pkg::INSN_W-1:0] de_insn;

    // Decode to execute
    logic [tinker_pkg::REG_AW-1:0] rs_addr;
    logic [tinker_pkg::REG_AW-1:0] rt_addr;
    logic                          rs_used;
    logic                          rt_used;
    logic [tinker_pkg::XLEN-1:0]   ex_pc;
    logic [tinker_pkg::OP_W-1:0]   ex_op;
    logic [tinker_pkg::XLEN-1:0]   ex_a;
    logic [tinker_pkg::XLEN-1:0]   ex_b;
    logic [tinker_pkg::XLEN-1:0]   ex_c;
    logic [tinker_pkg::LIT_W-1:0]  ex_lit;
    logic [tinker_pkg::REG_AW-1:0] ex_rd;
    logic                          ex_wr;
    logic                          ex_load;
    logic                          ex_store;

    // Execute and write-back
    logic [tinker_pkg::XLEN-1:0]   ex_result;
    logic [tinker_pkg::REG_AW-1:0] mem_rd;
    logic                          mem_wr;
    logic [tinker_pkg::XLEN-1:0]   wb_data;

    pipe_control u_control (.halted(hlt), .*);

    fetch_stage u_fetch (.halted(hlt), .*);

    decode_stage u_decode (.wb_rd(mem_rd), .wb_en(mem_wr), .*);

    execute_stage u_execute (.*);

endmodule

`default_nettype wire

// File: tb_tinker.sv
/* Testbench for the tinker core
   Directed programs, data memory model on the external bus */
`default_nettype none

module tb_tinker;

    localparam int RESET_CYCLES = 8;
    localparam int HALT_LIMIT   = 200;
    localparam int IDLE_CYCLES  = 8;
    localparam int N_RUNS       = 7;
    localparam int RUN_CYCLES   = 2**tinker_pkg::IMEM_AW + HALT_LIMIT + IDLE_CYCLES + 2;
    localparam int GLOBAL_LIMIT = N_RUNS * RUN_CYCLES;
    localparam logic [63:0] MARK = 64'h5A5;

    logic        clk;
    logic        reset;
    logic        load_en;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic        dmem_read;
    logic        dmem_write;
    logic [63:0] dmem_addr;
    logic [63:0] dmem_wdata;
    logic [63:0] dmem_rdata;
    logic        hlt;

    logic [31:0] prog [$];
    logic [63:0] exp_addr [$];
    logic [63:0] exp_data [$];
    logic [63:0] st_addr [$];
    logic [63:0] st_data [$];
    logic [63:0] dmem [logic [63:0]];
    int          errors;
    int          checks;
    int          tests_failed;
    int          cycle_count;

    tinker_core dut0 (.*);

    always #50 clk = ~clk;

    // ####################
    // Data memory, answers within the cycle
    always @(negedge clk) begin
        if (dmem_write) begin
            dmem[dmem_addr] = dmem_wdata;
            st_addr.push_back(dmem_addr);
            st_data.push_back(dmem_wdata);
        end
        if (dmem_read && dmem.exists(dmem_addr))
            dmem_rdata <= dmem[dmem_addr];
        else
            dmem_rdata <= '0;
    end

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // ####################
    // Program builder
    function automatic logic [31:0] rform(input logic [4:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        tinker_pkg::insn_t w;
        w = '0;
        w.r.opcode = op;
        w.r.rd = rd;
        w.r.rs = rs;
        w.r.rt = rt;
        return w;
    endfunction

    function automatic logic [31:0] iform(input logic [4:0] op, input logic [4:0] rd,
                                          input logic [11:0] lit);
        tinker_pkg::insn_t w;
        w = '0;
        w.i.opcode = op;
        w.i.rd = rd;
        w.i.lit = lit;
        return w;
    endfunction

    // Loads and stores use rs and the literal together
    function automatic logic [31:0] mform(input logic [4:0] op, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [11:0] lit);
        tinker_pkg::insn_t w;
        w = rform(op, rd, rs, 5'd0);
        w.i.lit = lit;
        return w;
    endfunction

    function automatic logic [63:0] sext(input logic [11:0] lit);
        return {{52{lit[11]}}, lit};
    endfunction

    task automatic put_const(input logic [4:0] r, input logic [63:0] v);
        prog.push_back(rform(tinker_pkg::OP_XOR, r, r, r));
        prog.push_back(iform(tinker_pkg::OP_MOV_LIT, r, {8'd0, v[63:60]}));
        for (int k = 4; k >= 0; k--) begin
            prog.push_back(iform(tinker_pkg::OP_SHFTLI, r, 12'd12));
            prog.push_back(iform(tinker_pkg::OP_MOV_LIT, r, v[k*12 +: 12]));
        end
    endtask

    // Store rs at r0 plus addr, optionally expected in the log
    task automatic emit_store(input logic [4:0] rs, input logic [63:0] addr, input bit seen,
                              input logic [63:0] value);
        prog.push_back(mform(tinker_pkg::OP_MOV_STR, 5'd0, rs, addr[11:0]));
        if (seen) begin
            exp_addr.push_back(addr);
            exp_data.push_back(value);
        end
    endtask

    // ####################
    // Run one program to halt
    task automatic run_program(output int latency);
        @(negedge clk);
        reset = 1'b1;
        st_addr.delete();
        st_data.delete();
        for (int i = 0; i < prog.size() || i < RESET_CYCLES; i++) begin
            load_en = i < prog.size();
            load_addr = i[7:0];
            load_data = (i < prog.size()) ? prog[i] : '0;
            @(negedge clk);
        end
        load_en = 1'b0;
        check_value("hlt", hlt, 0);
        check_value("dmem_read", dmem_read, 0);
        check_value("dmem_write", dmem_write, 0);
        reset = 1'b0;
        latency = 0;
        while (!hlt && latency < HALT_LIMIT) begin
            @(negedge clk);
            latency++;
        end
        if (!hlt) begin
            errors++;
            $display("hlt did not rise within %0d cycles", HALT_LIMIT);
        end else begin
            repeat (IDLE_CYCLES) begin
                @(negedge clk);
                check_value("hlt", hlt, 1);   // Must stay high
            end
        end
        check_value("store_count", st_addr.size(), exp_addr.size());
        for (int i = 0; i < st_addr.size() && i < exp_addr.size(); i++) begin
            check_value("dmem_addr", st_addr[i], exp_addr[i]);
            check_value("dmem_wdata", st_data[i], exp_data[i]);
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // ####################
    // Directed tests
    task automatic alu_case(input logic [4:0] op, input logic [63:0] value);
        prog.push_back(rform(op, 5'd3, 5'd1, 5'd2));
        emit_store(5'd3, 64'h100 + 8 * exp_addr.size(), 1'b1, value);
    endtask

    task automatic imm_case(input logic [4:0] op, input logic [11:0] lit, input logic [63:0] value);
        prog.push_back(rform(tinker_pkg::OP_MOV_REG, 5'd3, 5'd1, 5'd0));
        prog.push_back(iform(op, 5'd3, lit));
        emit_store(5'd3, 64'h100 + 8 * exp_addr.size(), 1'b1, value);
    endtask

    task automatic alu_ops();
        logic [63:0] a;
        logic [63:0] b;
        logic [11:0] lit;
        logic [11:0] sh;
        int          n;
        int          e0;
        e0 = errors;
        a = {$urandom, $urandom};
        b = {$urandom, $urandom};
        lit = $urandom;
        sh = {6'd0, b[21:16]};
        put_const(5'd1, a);
        put_const(5'd2, b);
        alu_case(tinker_pkg::OP_ADD, a + b);
        alu_case(tinker_pkg::OP_SUB, a - b);
        alu_case(tinker_pkg::OP_AND, a & b);
        alu_case(tinker_pkg::OP_OR, a | b);
        alu_case(tinker_pkg::OP_XOR, a ^ b);
        alu_case(tinker_pkg::OP_NOT, ~a);
        alu_case(tinker_pkg::OP_SHFTR, a >> b[5:0]);
        alu_case(tinker_pkg::OP_SHFTL, a << b[5:0]);
        alu_case(tinker_pkg::OP_MOV_REG, a);
        imm_case(tinker_pkg::OP_ADDI, lit, a + sext(lit));
        imm_case(tinker_pkg::OP_SUBI, lit, a - sext(lit));
        imm_case(tinker_pkg::OP_SHFTRI, sh, a >> sh[5:0]);
        imm_case(tinker_pkg::OP_SHFTLI, sh, a << sh[5:0]);
        imm_case(tinker_pkg::OP_MOV_LIT, lit, {a[63:12], lit});
        // Producer two ahead, bypass from write-back on rs then rt
        prog.push_back(rform(tinker_pkg::OP_ADD, 5'd4, 5'd1, 5'd2));
        prog.push_back(rform(tinker_pkg::OP_XOR, 5'd7, 5'd7, 5'd7));
        prog.push_back(rform(tinker_pkg::OP_XOR, 5'd6, 5'd4, 5'd2));
        emit_store(5'd6, 64'h1F0, 1'b1, (a + b) ^ b);
        prog.push_back(rform(tinker_pkg::OP_SUB, 5'd4, 5'd1, 5'd2));
        prog.push_back(rform(tinker_pkg::OP_XOR, 5'd7, 5'd7, 5'd7));
        prog.push_back(rform(tinker_pkg::OP_SUB, 5'd6, 5'd2, 5'd4));
        emit_store(5'd6, 64'h1F8, 1'b1, b - (a - b));
        prog.push_back(iform(tinker_pkg::OP_PRIV, 5'd0, 12'd0));
        run_program(n);
        report_test("alu ops", e0);
    endtask

    task automatic load_use();
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] z;
        int          n;
        int          e0;
        e0 = errors;
        x = {$urandom, $urandom};
        y = {$urandom, $urandom};
        z = {$urandom, $urandom};
        dmem.delete();
        dmem[64'h40] = x;
        dmem[64'h48] = z;
        put_const(5'd1, y);
        prog.push_back(mform(tinker_pkg::OP_MOV_MEM, 5'd2, 5'd0, 12'h040));
        prog.push_back(rform(tinker_pkg::OP_ADD, 5'd3, 5'd2, 5'd1));   // Uses load at once
        emit_store(5'd3, 64'h80, 1'b1, x + y);
        prog.push_back(iform(tinker_pkg::OP_MOV_LIT, 5'd5, 12'h040));
        prog.push_back(mform(tinker_pkg::OP_MOV_MEM, 5'd6, 5'd5, 12'h008));
        emit_store(5'd6, 64'h88, 1'b1, z);
        prog.push_back(mform(tinker_pkg::OP_MOV_MEM, 5'd7, 5'd0, 12'h048));
        prog.push_back(rform(tinker_pkg::OP_SUB, 5'd8, 5'd1, 5'd7));   // Load on rt
        emit_store(5'd8, 64'h90, 1'b1, y - z);
        prog.push_back(iform(tinker_pkg::OP_PRIV, 5'd0, 12'd0));
        run_program(n);
        report_test("load use", e0);
    endtask

    // Target sits past the two marker stores that a taken branch kills
    task automatic branch_case(input logic [4:0] op, input logic [4:0] rs, input logic [4:0] rt,
                               input bit taken, input int idx);
        logic [63:0] base;
        base = 64'h300 + 24 * idx;
        put_const(5'd4, tinker_pkg::RESET_PC + 4 * (prog.size() + 15));
        if (op == tinker_pkg::OP_BRRI)
            prog.push_back(iform(op, 5'd0, 12'd12));
        else
            prog.push_back(rform(op, 5'd4, rs, rt));
        emit_store(5'd3, base, !taken, MARK);
        emit_store(5'd3, base + 8, !taken, MARK);
        emit_store(5'd3, base + 16, 1'b1, MARK);
    endtask

    task automatic branches();
        int n;
        int e0;
        e0 = errors;
        prog.push_back(iform(tinker_pkg::OP_MOV_LIT, 5'd1, 12'd1));
        prog.push_back(iform(tinker_pkg::OP_SUBI, 5'd5, 12'd1));   // r5 = -1
        prog.push_back(iform(tinker_pkg::OP_MOV_LIT, 5'd3, MARK[11:0]));
        branch_case(tinker_pkg::OP_BRRI, 5'd0, 5'd0, 1'b1, 0);
        branch_case(tinker_pkg::OP_BR, 5'd0, 5'd0, 1'b1, 1);
        branch_case(tinker_pkg::OP_BRNZ, 5'd1, 5'd0, 1'b1, 2);
        branch_case(tinker_pkg::OP_BRNZ, 5'd2, 5'd0, 1'b0, 3);
        branch_case(tinker_pkg::OP_BRGT, 5'd1, 5'd5, 1'b1, 4);
        branch_case(tinker_pkg::OP_BRGT, 5'd5, 5'd1, 1'b0, 5);
        prog.push_back(iform(tinker_pkg::OP_PRIV, 5'd0, 12'd0));
        run_program(n);
        report_test("branches", e0);
    endtask

    task automatic halt_reload();
        int n;
        int e0;
        e0 = errors;
        prog.push_back(iform(tinker_pkg::OP_MOV_LIT, 5'd1, 12'h123));
        emit_store(5'd1, 64'h10, 1'b1, 64'h123);
        prog.push_back(iform(tinker_pkg::OP_PRIV, 5'd0, 12'd0));
        emit_store(5'd1, 64'h18, 1'b0, 64'h0);   // Behind the halt
        emit_store(5'd1, 64'h20, 1'b0, 64'h0);
        run_program(n);
        prog.push_back(iform(tinker_pkg::OP_MOV_LIT, 5'd5, 12'h321));
        prog.push_back(iform(tinker_pkg::OP_ADDI, 5'd5, 12'd1));
        emit_store(5'd5, 64'h28, 1'b1, 64'h322);
        prog.push_back(iform(tinker_pkg::OP_PRIV, 5'd0, 12'd0));
        run_program(n);
        report_test("halt and reload", e0);
    endtask

    task automatic reset_state();
        int n;
        int e0;
        e0 = errors;
        prog.push_back(iform(tinker_pkg::OP_PRIV, 5'd0, 12'd0));
        run_program(n);
        check_value("hlt_latency", n, 4);
        emit_store(5'd5, 64'h30, 1'b1, 64'h0);   // r5 was set by an earlier program
        prog.push_back(iform(tinker_pkg::OP_PRIV, 5'd0, 12'd0));
        run_program(n);
        report_test("reset state", e0);
    endtask

    // ####################
    initial begin
        cycle_count = 0;
        while (cycle_count < GLOBAL_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", GLOBAL_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        dmem_rdata = '0;
        errors = 0;
        checks = 0;
        tests_failed = 0;
        void'($urandom(32'h10d0_96d5));
        alu_ops();
        load_use();
        branches();
        halt_reload();
        reset_state();
        $display("summary: 5 tests, %0d failed, %0d checks, %0d errors",
                 tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
tinker_pkg.sv
pipe_control.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
tinker_core.sv
tb_tinker.sv

// File: Bender.yml
package:
  name: tinker_core

sources:
  - tinker_pkg.sv
  - pipe_control.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - tinker_core.sv
  - target: test
    files:
      - tb_tinker.sv
